/* alu/intAlu.sv */
module intAlu (
    input  execPkg::xlenT   rs1Data_i,
    input  execPkg::xlenT   rs2Data_i,
    input  execPkg::xlenT   imm_i,
    input  execPkg::addrT   instAddr_i,
    input  execPkg::opcodeT opCode_i,
    input  execPkg::funct3T funct3_i,
    input  execPkg::funct7T funct7_i,
    input  execPkg::shamtT  shamt_i,
    output execPkg::xlenT   rdData_o
);
    import execPkg::*;

    // Low word sign-extended to XLEN
    function automatic xlenT sext32(input logic [31:0] value);
        return {{(XLEN-32){value[31]}}, value};
    endfunction

    logic        useImm;
    logic        isBase;
    logic        isAlt;
    xlenT        opB;
    shamtT       shiftAmt;
    xlenT        addRes;
    xlenT        subRes;
    xlenT        sltRes;
    xlenT        sltuRes;
    xlenT        sllRes;
    xlenT        srlRes;
    xlenT        sraRes;
    logic [31:0] sllWord;
    logic [31:0] srlWord;
    logic [31:0] sraWord;
    xlenT        immUpper;
    xlenT        pcExt;
    xlenT        result;

    // Immediate forms share the register datapath
    assign useImm   = (opCode_i == OP_IMM) || (opCode_i == OP_IMM_W);
    assign opB      = useImm ? imm_i : rs2Data_i;
    assign shiftAmt = useImm ? shamt_i : rs2Data_i[SHAMT_W-1:0];

    // SLLI/SRLI/SRAI carry shamt[5] in funct7 bit 0
    always_comb begin
        if (opCode_i == OP_IMM) begin
            isBase = funct7_i[6:1] == F7_BASE[6:1];
            isAlt  = funct7_i[6:1] == F7_ALT[6:1];
        end else begin
            isBase = funct7_i == F7_BASE;
            isAlt  = funct7_i == F7_ALT;
        end
    end

    assign addRes  = rs1Data_i + opB;
    assign subRes  = rs1Data_i - rs2Data_i;
    // True signed and unsigned compares
    assign sltRes  = xlenT'($signed(rs1Data_i) < $signed(opB));
    assign sltuRes = xlenT'(rs1Data_i < opB);

    // Full-width shifters
    assign sllRes = rs1Data_i << shiftAmt;
    assign srlRes = rs1Data_i >> shiftAmt;
    assign sraRes = xlenT'($signed(rs1Data_i) >>> shiftAmt);

    // Word shifters, 5-bit amount on the low half only
    assign sllWord = rs1Data_i[31:0] << shiftAmt[4:0];
    assign srlWord = rs1Data_i[31:0] >> shiftAmt[4:0];
    assign sraWord = 32'($signed(rs1Data_i[31:0]) >>> shiftAmt[4:0]);

    assign immUpper = imm_i << 12;
    assign pcExt    = xlenT'(instAddr_i);

    always_comb begin
        result = '0;
        case (opCode_i)
            OP_IMM: begin
                case (funct3_i)
                    3'b000: result = addRes;
                    3'b010: result = sltRes;
                    3'b011: result = sltuRes;
                    3'b100: result = rs1Data_i ^ opB;
                    3'b110: result = rs1Data_i | opB;
                    3'b111: result = rs1Data_i & opB;
                    3'b001: result = isBase ? sllRes : '0;
                    // SRLI or SRAI
                    3'b101: result = isBase ? srlRes : (isAlt ? sraRes : '0);
                    default: result = '0;
                endcase
            end
            OP_REG: begin
                if (isBase) begin
                    case (funct3_i)
                        3'b000: result = addRes;
                        3'b001: result = sllRes;
                        3'b010: result = sltRes;
                        3'b011: result = sltuRes;
                        3'b100: result = rs1Data_i ^ opB;
                        3'b101: result = srlRes;
                        3'b110: result = rs1Data_i | opB;
                        3'b111: result = rs1Data_i & opB;
                        default: result = '0;
                    endcase
                end else if (isAlt) begin
                    // SUB and SRA only
                    if (funct3_i == 3'b000) begin
                        result = subRes;
                    end else if (funct3_i == 3'b101) begin
                        result = sraRes;
                    end
                end
            end
            OP_IMM_W: begin
                case (funct3_i)
                    3'b000: result = sext32(addRes[31:0]);
                    3'b001: result = isBase ? sext32(sllWord) : '0;
                    3'b101: result = isBase ? sext32(srlWord) : (isAlt ? sext32(sraWord) : '0);
                    default: result = '0;
                endcase
            end
            OP_REG_W: begin
                case (funct3_i)
                    3'b000: result = isBase ? sext32(addRes[31:0])
                                            : (isAlt ? sext32(subRes[31:0]) : '0);
                    3'b001: result = isBase ? sext32(sllWord) : '0;
                    3'b101: result = isBase ? sext32(srlWord) : (isAlt ? sext32(sraWord) : '0);
                    default: result = '0;
                endcase
            end
            OP_LUI:   result = sext32(immUpper[31:0]);
            OP_AUIPC: result = pcExt + immUpper;
            // Link value for both jumps
            OP_JAL, OP_JALR: result = pcExt + xlenT'(4);
            default: result = '0;
        endcase
    end

    assign rdData_o = result;

endmodule

/* common/execPkg.sv */
package execPkg;

    // Datapath widths
    localparam int XLEN       = 64;
    localparam int ADDR_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 6;
    localparam int PID_W      = 2;
    localparam int MASK_W     = 4;

    // Field types
    typedef logic [XLEN-1:0]       xlenT;
    typedef logic [ADDR_W-1:0]     addrT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [SHAMT_W-1:0]    shamtT;
    typedef logic [PID_W-1:0]      pidT;
    typedef logic [MASK_W-1:0]     maskT;
    typedef logic [6:0]            opcodeT;
    typedef logic [2:0]            funct3T;
    typedef logic [6:0]            funct7T;

    // Arithmetic opcode classes
    localparam opcodeT OP_IMM   = 7'b0010011;
    localparam opcodeT OP_REG   = 7'b0110011;
    localparam opcodeT OP_IMM_W = 7'b0011011;
    localparam opcodeT OP_REG_W = 7'b0111011;

    // Upper immediate, jumps and branches
    localparam opcodeT OP_LUI    = 7'b0110111;
    localparam opcodeT OP_AUIPC  = 7'b0010111;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_BRANCH = 7'b1100011;

    // Memory access
    localparam opcodeT OP_LOAD  = 7'b0000011;
    localparam opcodeT OP_STORE = 7'b0100011;

    // Funct7 variants
    localparam funct7T F7_BASE = 7'b0000000;
    // SUB and SRA flavour
    localparam funct7T F7_ALT  = 7'b0100000;

    // Branch conditions
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

    // Store size codes, one bit per access width
    localparam maskT MASK_SB = 4'b0001;
    localparam maskT MASK_SH = 4'b0010;
    localparam maskT MASK_SW = 4'b0100;
    localparam maskT MASK_SD = 4'b1000;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module executeStageTb \
    -Mdir "$BUILD_DIR" -o simExe > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/simExe" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$SIM_LOG"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1

/* sim.f */
common/execPkg.sv
alu/intAlu.sv
verilog/branchUnit.sv
verilog/memAddrGen.sv
verilog/resultReg.sv
verilog/executeStage.sv
tb/executeStage_assertions.sv
tb/executeStageTb.sv

/* tb/executeStageTb.sv */
module executeStageTb;
    timeunit 1ns;
    timeprecision 100ps;
    import execPkg::*;

    localparam int TIMEOUT      = 50;
    localparam int STALL_CYCLES = 5;

    // One instruction with every expected output
    typedef struct packed {
        opcodeT op;
        funct3T f3;
        funct7T f7;
        shamtT  shamt;
        addrT   pc;
        xlenT   rs1;
        xlenT   rs2;
        xlenT   imm;
        xlenT   expRd;
        logic   expJump;
        addrT   expJumpAddr;
        addrT   expReadAddr;
        addrT   expWriteAddr;
        xlenT   expWriteData;
        maskT   expMask;
        funct3T expMemF3;
    } rowT;

    logic    clk_i;
    logic    reset_i;
    logic    valid_i;
    logic    ready_o;
    logic    rdWriteEnable_i;
    regAddrT rdAddr_i;
    addrT    instAddr_i;
    xlenT    rs1Data_i;
    xlenT    rs2Data_i;
    xlenT    imm_i;
    opcodeT  opCode_i;
    funct3T  funct3_i;
    funct7T  funct7_i;
    shamtT   shamt_i;
    pidT     pid_i;
    logic    ready_i;
    logic    valid_o;
    logic    rdWriteEnable_o;
    regAddrT rdAddr_o;
    xlenT    rdData_o;
    pidT     pid_o;
    funct3T  memFunct3_o;
    addrT    readAddr_o;
    addrT    writeAddr_o;
    xlenT    writeData_o;
    maskT    writeMask_o;
    logic    jumpFlag_o;
    addrT    jumpAddr_o;

    rowT stimTable[$];
    int  errorCount = 0;
    int  timeoutCount = 0;
    // Row under test, for error lines
    int  curRow = -1;

    executeStage u_executeStage (.*);

    bind executeStage executeStageAssertions uAssertions (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .opCode_i    (opCode_i),
        .ready_i     (ready_i),
        .valid_o     (valid_o),
        .rdData_o    (rdData_o),
        .rdAddr_o    (rdAddr_o),
        .jumpFlag_o  (jumpFlag_o),
        .jumpAddr_o  (jumpAddr_o),
        .readAddr_o  (readAddr_o),
        .writeAddr_o (writeAddr_o),
        .writeData_o (writeData_o),
        .writeMask_o (writeMask_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic checkValue(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t ns row %0d: %s got %h expected %h",
                     $time, curRow, what, got, exp);
        end
    endtask

    // Signed order from the sign bits, unsigned order when they agree
    function automatic xlenT signedLess(input xlenT a, input xlenT b);
        if (a[63] != b[63]) begin
            return xlenT'(a[63]);
        end
        return xlenT'(a < b);
    endfunction

    // Logical shift, vacated top bits filled from the sign
    function automatic xlenT shiftRightArith(input xlenT a, input shamtT sh);
        xlenT fill;
        fill = '0;
        if (a[63]) begin
            fill = ~({XLEN{1'b1}} >> sh);
        end
        return (a >> sh) | fill;
    endfunction

    // ALU rows, fixed pc, no jump and no memory side effects
    task automatic addAlu(input opcodeT op, input funct3T f3, input funct7T f7,
                          input xlenT rs1, input xlenT rs2, input xlenT imm,
                          input shamtT sh, input xlenT expRd);
        rowT r;
        r = '0;
        r.op    = op;
        r.f3    = f3;
        r.f7    = f7;
        r.rs1   = rs1;
        r.rs2   = rs2;
        r.imm   = imm;
        r.shamt = sh;
        r.pc    = 32'h0000_1000;
        r.expRd = expRd;
        stimTable.push_back(r);
    endtask

    task automatic addJump(input opcodeT op, input xlenT rs1, input xlenT imm,
                           input addrT target);
        rowT r;
        r = '0;
        r.op          = op;
        r.rs1         = rs1;
        r.imm         = imm;
        r.pc          = 32'h0000_2000;
        // Link is pc plus 4
        r.expRd       = 64'h2004;
        r.expJump     = 1'b1;
        r.expJumpAddr = target;
        stimTable.push_back(r);
    endtask

    // Branch back by 16 from 0x1000
    task automatic addBranch(input funct3T f3, input xlenT rs1, input xlenT rs2,
                             input logic taken);
        rowT r;
        r = '0;
        r.op          = OP_BRANCH;
        r.f3          = f3;
        r.rs1         = rs1;
        r.rs2         = rs2;
        r.imm         = 64'hFFFF_FFFF_FFFF_FFF0;
        r.pc          = 32'h0000_1000;
        r.expJump     = taken;
        r.expJumpAddr = 32'h0000_0FF0;
        stimTable.push_back(r);
    endtask

    // Base 0x2000 minus 4
    task automatic addMem(input opcodeT op, input funct3T f3, input maskT mask);
        rowT r;
        r = '0;
        r.op       = op;
        r.f3       = f3;
        r.rs1      = 64'h2000;
        r.rs2      = 64'hDEAD_BEEF_CAFE_F00D;
        r.imm      = 64'hFFFF_FFFF_FFFF_FFFC;
        r.expMemF3 = f3;
        if (op == OP_LOAD) begin
            r.expReadAddr = 32'h0000_1FFC;
        end else begin
            r.expWriteAddr = 32'h0000_1FFC;
            r.expWriteData = 64'hDEAD_BEEF_CAFE_F00D;
            r.expMask      = mask;
        end
        stimTable.push_back(r);
    endtask

    // Random operand pairs, both signs
    task automatic addRandomRows(input int count);
        xlenT a;
        xlenT b;
        for (int k = 0; k < count; k++) begin
            a = {$urandom(), $urandom()};
            b = {$urandom(), $urandom()};
            addAlu(OP_REG, 3'b000, F7_BASE, a, b, '0, '0, a + b);
            addAlu(OP_REG, 3'b000, F7_ALT, a, b, '0, '0, a - b);
            addAlu(OP_REG, 3'b100, F7_BASE, a, b, '0, '0, a ^ b);
            addAlu(OP_REG, 3'b010, F7_BASE, a, b, '0, '0, signedLess(a, b));
            addAlu(OP_REG, 3'b011, F7_BASE, a, b, '0, '0, xlenT'(a < b));
            addAlu(OP_REG, 3'b101, F7_ALT, a, b, '0, '0, shiftRightArith(a, b[5:0]));
        end
    endtask

    task automatic buildTable();
        // R-type
        addAlu(OP_REG, 3'b000, F7_BASE, 64'd5, 64'hFFFF_FFFF_FFFF_FFFD, '0, '0, 64'd2);
        addAlu(OP_REG, 3'b000, F7_ALT, 64'd5, 64'd7, '0, '0, 64'hFFFF_FFFF_FFFF_FFFE);
        addAlu(OP_REG, 3'b111, F7_BASE, 64'hF0F0, 64'hFF00, '0, '0, 64'hF000);
        addAlu(OP_REG, 3'b110, F7_BASE, 64'hF0F0, 64'hFF00, '0, '0, 64'hFFF0);
        addAlu(OP_REG, 3'b100, F7_BASE, 64'hF0F0, 64'hFF00, '0, '0, 64'h0FF0);
        addAlu(OP_REG, 3'b010, F7_BASE, '1, 64'd1, '0, '0, 64'd1);
        addAlu(OP_REG, 3'b011, F7_BASE, '1, 64'd1, '0, '0, 64'd0);
        addAlu(OP_REG, 3'b001, F7_BASE, 64'd1, 64'd63, '0, '0, 64'h8000_0000_0000_0000);
        addAlu(OP_REG, 3'b101, F7_BASE, 64'h8000_0000_0000_0000, 64'd4, '0, '0,
               64'h0800_0000_0000_0000);
        addAlu(OP_REG, 3'b101, F7_ALT, 64'h8000_0000_0000_0000, 64'd4, '0, '0,
               64'hF800_0000_0000_0000);
        // I-type, shamt[5] sits in funct7 bit 0
        addAlu(OP_IMM, 3'b000, '0, 64'd10, '0, 64'hFFFF_FFFF_FFFF_FFEC, '0,
               64'hFFFF_FFFF_FFFF_FFF6);
        addAlu(OP_IMM, 3'b010, '0, 64'hFFFF_FFFF_FFFF_FFFB, '0, 64'd3, '0, 64'd1);
        addAlu(OP_IMM, 3'b001, 7'b0000001, 64'd3, '0, '0, 6'd40, 64'h0000_0300_0000_0000);
        addAlu(OP_IMM, 3'b101, 7'b0100001, 64'h8000_0000_0000_0000, '0, '0, 6'd36,
               64'hFFFF_FFFF_F800_0000);
        // Word forms
        addAlu(OP_REG_W, 3'b000, F7_BASE, 64'h7FFF_FFFF, 64'd1, '0, '0, 64'hFFFF_FFFF_8000_0000);
        addAlu(OP_REG_W, 3'b000, F7_ALT, 64'h1234_5678_0000_0000, 64'd1, '0, '0, '1);
        addAlu(OP_REG_W, 3'b001, F7_BASE, 64'd1, 64'd31, '0, '0, 64'hFFFF_FFFF_8000_0000);
        addAlu(OP_REG_W, 3'b101, F7_ALT, 64'h8000_0000, 64'd4, '0, '0, 64'hFFFF_FFFF_F800_0000);
        addAlu(OP_IMM_W, 3'b000, '0, 64'h0000_0001_7FFF_FFFF, '0, 64'd1, '0,
               64'hFFFF_FFFF_8000_0000);
        // Upper immediates at pc 0x1000
        addAlu(OP_LUI, '0, '0, '0, '0, 64'h8_0000, '0, 64'hFFFF_FFFF_8000_0000);
        addAlu(OP_AUIPC, '0, '0, '0, '0, 64'd1, '0, 64'h2000);
        addJump(OP_JAL, '0, 64'h100, 32'h0000_2100);
        addJump(OP_JALR, 64'h4001, 64'h10, 32'h0000_4010);
        // Taken and not-taken pairs
        addBranch(F3_BEQ, 64'd5, 64'd5, 1'b1);
        addBranch(F3_BEQ, 64'd5, 64'd6, 1'b0);
        addBranch(F3_BNE, 64'd5, 64'd6, 1'b1);
        addBranch(F3_BNE, 64'd5, 64'd5, 1'b0);
        addBranch(F3_BLT, '1, 64'd1, 1'b1);
        addBranch(F3_BLT, 64'd1, '1, 1'b0);
        addBranch(F3_BGE, 64'd1, '1, 1'b1);
        addBranch(F3_BGE, '1, 64'd1, 1'b0);
        addBranch(F3_BLTU, '1, 64'd1, 1'b0);
        addBranch(F3_BLTU, 64'd1, '1, 1'b1);
        addBranch(F3_BGEU, '1, 64'd1, 1'b1);
        addBranch(F3_BGEU, 64'd1, '1, 1'b0);
        // Loads and every store width
        addMem(OP_LOAD, 3'b011, '0);
        addMem(OP_LOAD, 3'b100, '0);
        addMem(OP_STORE, 3'b000, MASK_SB);
        addMem(OP_STORE, 3'b001, MASK_SH);
        addMem(OP_STORE, 3'b010, MASK_SW);
        addMem(OP_STORE, 3'b011, MASK_SD);
        addRandomRows(6);
    endtask

    // Pass-through fields follow the row index
    task automatic driveRow(input int idx);
        rowT r;
        r = stimTable[idx];
        curRow          = idx;
        valid_i         = 1'b1;
        rdWriteEnable_i = idx[0];
        rdAddr_i        = regAddrT'(idx);
        pid_i           = pidT'(idx);
        instAddr_i      = r.pc;
        rs1Data_i       = r.rs1;
        rs2Data_i       = r.rs2;
        imm_i           = r.imm;
        opCode_i        = r.op;
        funct3_i        = r.f3;
        funct7_i        = r.f7;
        shamt_i         = r.shamt;
    endtask

    task automatic checkRow(input int idx);
        rowT r;
        r = stimTable[idx];
        checkValue("valid_o", 64'(valid_o), 64'd1);
        checkValue("rdWriteEnable_o", 64'(rdWriteEnable_o), 64'(idx[0]));
        checkValue("rdAddr_o", 64'(rdAddr_o), 64'(regAddrT'(idx)));
        checkValue("pid_o", 64'(pid_o), 64'(pidT'(idx)));
        checkValue("rdData_o", rdData_o, r.expRd);
        checkValue("jumpFlag_o", 64'(jumpFlag_o), 64'(r.expJump));
        checkValue("jumpAddr_o", 64'(jumpAddr_o), 64'(r.expJumpAddr));
        checkValue("readAddr_o", 64'(readAddr_o), 64'(r.expReadAddr));
        checkValue("writeAddr_o", 64'(writeAddr_o), 64'(r.expWriteAddr));
        checkValue("writeData_o", writeData_o, r.expWriteData);
        checkValue("writeMask_o", 64'(writeMask_o), 64'(r.expMask));
        checkValue("memFunct3_o", 64'(memFunct3_o), 64'(r.expMemF3));
    endtask

    // Sample ready_o mid-cycle, return just after the accepting edge
    task automatic waitAccept();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk_i);
            seen = ready_o;
            @(posedge clk_i);
            #1;
            n++;
        end
        if (!seen) begin
            timeoutCount++;
            $display("Timeout: the DUT never accepted row %0d", curRow);
        end
    endtask

    task automatic waitValid();
        int n;
        n = 0;
        while (valid_o !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (valid_o !== 1'b1) begin
            timeoutCount++;
            $display("Timeout: no valid result came out for row %0d", curRow);
        end
    endtask

    // Item A stalls in the register while item B waits at the input
    task automatic stallTest();
        // Last item of the previous pass leaves first
        @(posedge clk_i);
        #1;
        ready_i = 1'b0;
        driveRow(0);
        waitAccept();
        checkRow(0);
        driveRow(1);
        repeat (STALL_CYCLES) begin
            @(negedge clk_i);
            curRow = 0;
            checkValue("ready_o under stall", 64'(ready_o), 64'd0);
            @(posedge clk_i);
            #1;
            checkRow(0);
        end
        ready_i = 1'b1;
        curRow  = 1;
        waitAccept();
        valid_i = 1'b0;
        checkRow(1);
        @(posedge clk_i);
        #1;
        checkValue("valid_o after drain", 64'(valid_o), 64'd0);
    endtask

    initial begin
        void'($urandom(32'ha4d2ca90));
        reset_i         = 1'b1;
        valid_i         = 1'b0;
        ready_i         = 1'b0;
        rdWriteEnable_i = 1'b0;
        rdAddr_i        = '0;
        instAddr_i      = '0;
        rs1Data_i       = '0;
        rs2Data_i       = '0;
        imm_i           = '0;
        opCode_i        = '0;
        funct3_i        = '0;
        funct7_i        = '0;
        shamt_i         = '0;
        pid_i           = '0;
        buildTable();

        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        checkValue("valid_o after reset", 64'(valid_o), 64'd0);
        checkValue("jumpFlag_o after reset", 64'(jumpFlag_o), 64'd0);
        checkValue("rdWriteEnable_o after reset", 64'(rdWriteEnable_o), 64'd0);
        checkValue("writeMask_o after reset", 64'(writeMask_o), 64'd0);

        // One row at a time, consumer always ready
        ready_i = 1'b1;
        for (int i = 0; i < stimTable.size(); i++) begin
            driveRow(i);
            waitAccept();
            valid_i = 1'b0;
            waitValid();
            checkRow(i);
        end

        stallTest();

        // Back to back, each result one cycle after its accepting edge
        for (int i = 0; i < stimTable.size(); i++) begin
            driveRow(i);
            waitAccept();
            checkRow(i);
        end
        valid_i = 1'b0;
        repeat (2) @(posedge clk_i);

        $display("Run finished with %0d errors and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb/executeStage_assertions.sv */
module executeStageAssertions (
    input logic             clk_i,
    input logic             reset_i,
    input logic             valid_i,
    input logic             ready_o,
    input execPkg::opcodeT  opCode_i,
    input logic             ready_i,
    input logic             valid_o,
    input execPkg::xlenT    rdData_o,
    input execPkg::regAddrT rdAddr_o,
    input logic             jumpFlag_o,
    input execPkg::addrT    jumpAddr_o,
    input execPkg::addrT    readAddr_o,
    input execPkg::addrT    writeAddr_o,
    input execPkg::xlenT    writeData_o,
    input execPkg::maskT    writeMask_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import execPkg::*;

    // Opcode class of the item now held in the output register
    logic heldJalr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            heldJalr <= 1'b0;
        end else if (valid_i && ready_o) begin
            heldJalr <= opCode_i == OP_JALR;
        end
    end

    // One size code at most
    maskOneHot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(writeMask_o))
        else $error("writeMask_o has more than one bit set");

    // Stalled item stays put
    holdUnderStall: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o && !ready_i |=> valid_o && $stable(rdData_o) && $stable(rdAddr_o)
            && $stable(jumpFlag_o) && $stable(jumpAddr_o) && $stable(readAddr_o)
            && $stable(writeAddr_o) && $stable(writeData_o) && $stable(writeMask_o))
        else $error("outputs changed while the consumer stalled");

    jalrTargetAligned: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o && heldJalr |-> !jumpAddr_o[0])
        else $error("JALR target has bit 0 set");

endmodule

/* verilog/branchUnit.sv */
module branchUnit (
    input  execPkg::xlenT   rs1Data_i,
    input  execPkg::xlenT   rs2Data_i,
    input  execPkg::xlenT   imm_i,
    input  execPkg::addrT   instAddr_i,
    input  execPkg::opcodeT opCode_i,
    input  execPkg::funct3T funct3_i,
    output logic            jumpFlag_o,
    output execPkg::addrT   jumpAddr_o
);
    import execPkg::*;

    logic isEqual;
    logic ltSigned;
    logic ltUnsigned;
    logic condTrue;
    addrT pcTarget;
    addrT regTarget;

    // Full 64-bit compares
    assign isEqual    = rs1Data_i == rs2Data_i;
    assign ltSigned   = $signed(rs1Data_i) < $signed(rs2Data_i);
    assign ltUnsigned = rs1Data_i < rs2Data_i;

    // PC-relative target for JAL and branches
    assign pcTarget  = instAddr_i + imm_i[ADDR_W-1:0];
    // JALR drops bit 0
    assign regTarget = (rs1Data_i[ADDR_W-1:0] + imm_i[ADDR_W-1:0]) & ~addrT'(1);

    always_comb begin
        case (funct3_i)
            F3_BEQ:  condTrue = isEqual;
            F3_BNE:  condTrue = !isEqual;
            F3_BLT:  condTrue = ltSigned;
            F3_BGE:  condTrue = !ltSigned;
            F3_BLTU: condTrue = ltUnsigned;
            F3_BGEU: condTrue = !ltUnsigned;
            default: condTrue = 1'b0;
        endcase
    end

    always_comb begin
        jumpFlag_o = 1'b0;
        jumpAddr_o = '0;
        case (opCode_i)
            OP_JAL: begin
                jumpFlag_o = 1'b1;
                jumpAddr_o = pcTarget;
            end
            OP_JALR: begin
                jumpFlag_o = 1'b1;
                jumpAddr_o = regTarget;
            end
            // Target given even when not taken
            OP_BRANCH: begin
                jumpFlag_o = condTrue;
                jumpAddr_o = pcTarget;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/executeStage.sv */
module executeStage (
    input  logic             clk_i,
    input  logic             reset_i,
    // Issue side
    input  logic             valid_i,
    output logic             ready_o,
    input  logic             rdWriteEnable_i,
    input  execPkg::regAddrT rdAddr_i,
    input  execPkg::addrT    instAddr_i,
    input  execPkg::xlenT    rs1Data_i,
    input  execPkg::xlenT    rs2Data_i,
    input  execPkg::xlenT    imm_i,
    input  execPkg::opcodeT  opCode_i,
    input  execPkg::funct3T  funct3_i,
    input  execPkg::funct7T  funct7_i,
    input  execPkg::shamtT   shamt_i,
    input  execPkg::pidT     pid_i,
    // Consumer side
    input  logic             ready_i,
    output logic             valid_o,
    output logic             rdWriteEnable_o,
    output execPkg::regAddrT rdAddr_o,
    output execPkg::xlenT    rdData_o,
    output execPkg::pidT     pid_o,
    output execPkg::funct3T  memFunct3_o,
    output execPkg::addrT    readAddr_o,
    output execPkg::addrT    writeAddr_o,
    output execPkg::xlenT    writeData_o,
    output execPkg::maskT    writeMask_o,
    // Toward the PC unit
    output logic             jumpFlag_o,
    output execPkg::addrT    jumpAddr_o
);
    import execPkg::*;

    // Unregistered unit results
    xlenT   aluResult;
    logic   jumpFlag;
    addrT   jumpAddr;
    addrT   readAddr;
    addrT   writeAddr;
    xlenT   writeData;
    maskT   writeMask;
    funct3T memFunct3;

    intAlu uAlu (
        .rs1Data_i  (rs1Data_i),
        .rs2Data_i  (rs2Data_i),
        .imm_i      (imm_i),
        .instAddr_i (instAddr_i),
        .opCode_i   (opCode_i),
        .funct3_i   (funct3_i),
        .funct7_i   (funct7_i),
        .shamt_i    (shamt_i),
        .rdData_o   (aluResult)
    );

    branchUnit uBranch (
        .rs1Data_i  (rs1Data_i),
        .rs2Data_i  (rs2Data_i),
        .imm_i      (imm_i),
        .instAddr_i (instAddr_i),
        .opCode_i   (opCode_i),
        .funct3_i   (funct3_i),
        .jumpFlag_o (jumpFlag),
        .jumpAddr_o (jumpAddr)
    );

    memAddrGen uMem (
        .rs1Data_i   (rs1Data_i),
        .rs2Data_i   (rs2Data_i),
        .imm_i       (imm_i),
        .opCode_i    (opCode_i),
        .funct3_i    (funct3_i),
        .readAddr_o  (readAddr),
        .writeAddr_o (writeAddr),
        .writeData_o (writeData),
        .writeMask_o (writeMask),
        .memFunct3_o (memFunct3)
    );

    // Single register stage, owns the handshake
    resultReg uResult (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_i         (valid_i),
        .ready_i         (ready_i),
        .rdWriteEnable_i (rdWriteEnable_i),
        .rdAddr_i        (rdAddr_i),
        .pid_i           (pid_i),
        .rdData_i        (aluResult),
        .jumpFlag_i      (jumpFlag),
        .jumpAddr_i      (jumpAddr),
        .readAddr_i      (readAddr),
        .writeAddr_i     (writeAddr),
        .writeData_i     (writeData),
        .writeMask_i     (writeMask),
        .memFunct3_i     (memFunct3),
        .ready_o         (ready_o),
        .valid_o         (valid_o),
        .rdWriteEnable_o (rdWriteEnable_o),
        .rdAddr_o        (rdAddr_o),
        .pid_o           (pid_o),
        .rdData_o        (rdData_o),
        .jumpFlag_o      (jumpFlag_o),
        .jumpAddr_o      (jumpAddr_o),
        .readAddr_o      (readAddr_o),
        .writeAddr_o     (writeAddr_o),
        .writeData_o     (writeData_o),
        .writeMask_o     (writeMask_o),
        .memFunct3_o     (memFunct3_o)
    );

endmodule

/* verilog/memAddrGen.sv */
module memAddrGen (
    input  execPkg::xlenT   rs1Data_i,
    input  execPkg::xlenT   rs2Data_i,
    input  execPkg::xlenT   imm_i,
    input  execPkg::opcodeT opCode_i,
    input  execPkg::funct3T funct3_i,
    output execPkg::addrT   readAddr_o,
    output execPkg::addrT   writeAddr_o,
    output execPkg::xlenT   writeData_o,
    output execPkg::maskT   writeMask_o,
    output execPkg::funct3T memFunct3_o
);
    import execPkg::*;

    logic isLoad;
    logic isStore;
    addrT effAddr;
    maskT sizeMask;

    assign isLoad  = opCode_i == OP_LOAD;
    assign isStore = opCode_i == OP_STORE;

    // Base plus offset, low word only
    assign effAddr = rs1Data_i[ADDR_W-1:0] + imm_i[ADDR_W-1:0];

    // Store width from funct3
    always_comb begin
        case (funct3_i)
            3'b000:  sizeMask = MASK_SB;
            3'b001:  sizeMask = MASK_SH;
            3'b010:  sizeMask = MASK_SW;
            3'b011:  sizeMask = MASK_SD;
            default: sizeMask = '0;
        endcase
    end

    assign readAddr_o  = isLoad ? effAddr : '0;
    assign writeAddr_o = isStore ? effAddr : '0;
    assign writeData_o = isStore ? rs2Data_i : '0;
    assign writeMask_o = isStore ? sizeMask : '0;
    // Size and sign info for the memory stage
    assign memFunct3_o = (isLoad || isStore) ? funct3_i : '0;

endmodule

/* verilog/resultReg.sv */
module resultReg (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             valid_i,
    input  logic             ready_i,
    input  logic             rdWriteEnable_i,
    input  execPkg::regAddrT rdAddr_i,
    input  execPkg::pidT     pid_i,
    input  execPkg::xlenT    rdData_i,
    input  logic             jumpFlag_i,
    input  execPkg::addrT    jumpAddr_i,
    input  execPkg::addrT    readAddr_i,
    input  execPkg::addrT    writeAddr_i,
    input  execPkg::xlenT    writeData_i,
    input  execPkg::maskT    writeMask_i,
    input  execPkg::funct3T  memFunct3_i,
    output logic             ready_o,
    output logic             valid_o,
    output logic             rdWriteEnable_o,
    output execPkg::regAddrT rdAddr_o,
    output execPkg::pidT     pid_o,
    output execPkg::xlenT    rdData_o,
    output logic             jumpFlag_o,
    output execPkg::addrT    jumpAddr_o,
    output execPkg::addrT    readAddr_o,
    output execPkg::addrT    writeAddr_o,
    output execPkg::xlenT    writeData_o,
    output execPkg::maskT    writeMask_o,
    output execPkg::funct3T  memFunct3_o
);

    logic accept;

    // Free slot, or the held item leaves this cycle
    assign ready_o = !valid_o || ready_i;
    assign accept  = valid_i && ready_o;

    // Control fields
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o         <= 1'b0;
            rdWriteEnable_o <= 1'b0;
            jumpFlag_o      <= 1'b0;
            writeMask_o     <= '0;
        end else if (accept) begin
            valid_o         <= 1'b1;
            rdWriteEnable_o <= rdWriteEnable_i;
            jumpFlag_o      <= jumpFlag_i;
            writeMask_o     <= writeMask_i;
        end else if (ready_i) begin
            // Drained with nothing behind it
            valid_o <= 1'b0;
        end
    end

    // Payload, held while stalled
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdAddr_o    <= rdAddr_i;
            pid_o       <= pid_i;
            rdData_o    <= rdData_i;
            jumpAddr_o  <= jumpAddr_i;
            readAddr_o  <= readAddr_i;
            writeAddr_o <= writeAddr_i;
            writeData_o <= writeData_i;
            memFunct3_o <= memFunct3_i;
        end
    end

endmodule
